//--- Bender.yml
package:
  name: repvgg_acc

sources:
  - files:
      - src/acc_bus_pkg.sv
      - src/acc_cfg_pkg.sv
      - src/mem_req_if.sv
      - src/acc_regs.sv
      - src/icb_arbiter.sv
      - src/map_stream.sv
      - src/repvgg_acc_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/repvgg_acc_props.sv
      - tb/repvgg_acc_tb.sv

//--- repvgg_acc_top.f
src/acc_bus_pkg.sv
src/acc_cfg_pkg.sv
src/mem_req_if.sv
src/acc_regs.sv
src/icb_arbiter.sv
src/map_stream.sv
src/repvgg_acc_top.sv
tb/tb_clk_gen.sv
tb/repvgg_acc_props.sv
tb/repvgg_acc_tb.sv

//--- src/acc_bus_pkg.sv
/*
 * ICB bus definitions shared by the slave and master ports
 *   - address, data and byte-mask widths
 *   - word types for address, data and mask
 */
package acc_bus_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int MASK_W = DATA_W / 8;    // one bit per byte lane

    // ------------------------------------------------------------------
    // bus word types
    // ------------------------------------------------------------------
    typedef logic [ADDR_W-1:0] bus_addr_t;
    typedef logic [DATA_W-1:0] bus_data_t;
    typedef logic [MASK_W-1:0] bus_mask_t;

endpackage

//--- src/acc_cfg_pkg.sv
/*
 * Accelerator configuration definitions
 *   - register offsets of the slave register map
 *   - activation and weight field types
 *   - product shift and lanes per bus word
 */
package acc_cfg_pkg;

    localparam int OFF_W = 8;              // decoded low address bits
    localparam int ACT_W = 8;
    localparam int WEIGHT_W = 8;

    typedef logic [OFF_W-1:0] reg_off_t;

    // register map
    localparam reg_off_t REG_START    = 8'h00;
    localparam reg_off_t REG_DONE     = 8'h04;
    localparam reg_off_t REG_IN_ADDR  = 8'h08;
    localparam reg_off_t REG_OUT_ADDR = 8'h0C;
    localparam reg_off_t REG_WORDS    = 8'h10;
    localparam reg_off_t REG_WEIGHT   = 8'h14;

    typedef logic signed [ACT_W-1:0]    act_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;

    localparam int PROD_SHIFT = 4;         // scale back the 16-bit product
    localparam int LANES = 4;              // int8 activations per word

endpackage

//--- src/acc_regs.sv
/*
 * ICB slave register block
 *   - byte-masked writes into the configuration registers
 *   - one-deep response register with error on unmapped offsets
 *   - start pulse, busy tracking and sticky done flag
 */
`timescale 1ns/1ps

module acc_regs #(
    parameter int CNT_W = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  icb_cmd_valid,
    output logic                  icb_cmd_ready,
    input  logic                  icb_cmd_read,
    input  acc_bus_pkg::bus_addr_t icb_cmd_addr,
    input  acc_bus_pkg::bus_data_t icb_cmd_wdata,
    input  acc_bus_pkg::bus_mask_t icb_cmd_wmask,
    output logic                  icb_rsp_valid,
    input  logic                  icb_rsp_ready,
    output acc_bus_pkg::bus_data_t icb_rsp_rdata,
    output logic                  icb_rsp_err,

    output logic                  start,
    output acc_bus_pkg::bus_addr_t in_addr,
    output acc_bus_pkg::bus_addr_t out_addr,
    output logic [CNT_W-1:0]      words,
    output acc_cfg_pkg::weight_t  weight,
    input  logic                  done
);
    import acc_bus_pkg::*;
    import acc_cfg_pkg::*;

    reg_off_t  off;
    logic      cmd_fire;
    logic      wr_fire;
    logic      hit;
    logic      busy;
    logic      done_flag;
    bus_data_t cur_val;                    // current value at the addressed offset
    bus_data_t merged;

    function automatic bus_data_t merge_bytes(bus_data_t cur, bus_data_t wdata,
                                              bus_mask_t mask);
        bus_data_t res;
        res = cur;
        for (int b = 0; b < MASK_W; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign off           = icb_cmd_addr[OFF_W-1:0];
    assign icb_cmd_ready = ~icb_rsp_valid;  // back-pressure while a response waits
    assign cmd_fire      = icb_cmd_valid & icb_cmd_ready;
    assign wr_fire       = cmd_fire & ~icb_cmd_read;
    assign merged        = merge_bytes(cur_val, icb_cmd_wdata, icb_cmd_wmask);

    // ------------------------------------------------------------------
    // offset decode
    // ------------------------------------------------------------------
    always_comb begin
        cur_val = '0;
        hit     = 1'b1;
        case (off)
            REG_START:    cur_val = '0;    // write-only pulse
            REG_DONE:     cur_val = {{(DATA_W-1){1'b0}}, done_flag};
            REG_IN_ADDR:  cur_val = in_addr;
            REG_OUT_ADDR: cur_val = out_addr;
            REG_WORDS:    cur_val = {{(DATA_W-CNT_W){1'b0}}, words};
            REG_WEIGHT:   cur_val = {{(DATA_W-WEIGHT_W){1'b0}}, weight};
            default:      hit     = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_addr       <= '0;
            out_addr      <= '0;
            words         <= '0;
            weight        <= '0;
            start         <= 1'b0;
            busy          <= 1'b0;
            done_flag     <= 1'b0;
            icb_rsp_valid <= 1'b0;
        end else begin
            start <= wr_fire && (off == REG_START) && icb_cmd_wmask[0]
                     && icb_cmd_wdata[0] && !busy;
            if (start) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;         // new run clears done
            end else if (done) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
            end
            if (wr_fire) begin
                case (off)
                    REG_IN_ADDR:  in_addr  <= merged;
                    REG_OUT_ADDR: out_addr <= merged;
                    REG_WORDS:    words    <= merged[CNT_W-1:0];
                    REG_WEIGHT:   weight   <= merged[WEIGHT_W-1:0];
                    default:      ;        // start, done and holes keep state
                endcase
            end
            if (cmd_fire) begin
                icb_rsp_valid <= 1'b1;
            end else if (icb_rsp_ready) begin
                icb_rsp_valid <= 1'b0;
            end
        end
    end

    // response payload, held until accepted
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            icb_rsp_rdata <= (icb_cmd_read && hit) ? cur_val : '0;
            icb_rsp_err   <= ~hit;
        end
    end

endmodule

//--- src/icb_arbiter.sv
/*
 * ICB master arbiter
 *   - write channel has priority over read channel
 *   - one transaction in flight, grant held until the response
 */
`timescale 1ns/1ps

module icb_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,

    mem_req_if.arbiter             rd_ch,
    mem_req_if.arbiter             wr_ch,

    output logic                   acc_icb_cmd_valid,
    input  logic                   acc_icb_cmd_ready,
    output acc_bus_pkg::bus_addr_t acc_icb_cmd_addr,
    output logic                   acc_icb_cmd_read,
    output acc_bus_pkg::bus_data_t acc_icb_cmd_wdata,
    output acc_bus_pkg::bus_mask_t acc_icb_cmd_wmask,
    input  logic                   acc_icb_rsp_valid,
    output logic                   acc_icb_rsp_ready,
    input  logic                   acc_icb_rsp_err,
    input  acc_bus_pkg::bus_data_t acc_icb_rsp_rdata
);
    import acc_bus_pkg::*;

    localparam bus_mask_t FULL_MASK = '1;

    logic locked;                          // client selection frozen
    logic gnt_wr;                          // locked client, 1 = write channel
    logic cmd_done;                        // command accepted, response pending
    logic cur_wr;

    assign cur_wr = locked ? gnt_wr : wr_ch.cmd_valid;

    // ------------------------------------------------------------------
    // command path
    // ------------------------------------------------------------------
    assign acc_icb_cmd_valid = ~cmd_done & (cur_wr ? wr_ch.cmd_valid : rd_ch.cmd_valid);
    assign acc_icb_cmd_addr  = cur_wr ? wr_ch.cmd_addr  : rd_ch.cmd_addr;
    assign acc_icb_cmd_read  = cur_wr ? wr_ch.cmd_read  : rd_ch.cmd_read;
    assign acc_icb_cmd_wdata = cur_wr ? wr_ch.cmd_wdata : rd_ch.cmd_wdata;
    assign acc_icb_cmd_wmask = FULL_MASK;  // full words only

    assign wr_ch.cmd_ready = ~cmd_done &  cur_wr & acc_icb_cmd_ready;
    assign rd_ch.cmd_ready = ~cmd_done & ~cur_wr & acc_icb_cmd_ready;

    // ------------------------------------------------------------------
    // response path, routed by the grant
    // ------------------------------------------------------------------
    assign acc_icb_rsp_ready = cmd_done & (gnt_wr ? wr_ch.rsp_ready : rd_ch.rsp_ready);

    assign wr_ch.rsp_valid = cmd_done &  gnt_wr & acc_icb_rsp_valid;
    assign rd_ch.rsp_valid = cmd_done & ~gnt_wr & acc_icb_rsp_valid;
    assign wr_ch.rsp_rdata = acc_icb_rsp_rdata;
    assign rd_ch.rsp_rdata = acc_icb_rsp_rdata;
    assign wr_ch.rsp_err   = acc_icb_rsp_err;
    assign rd_ch.rsp_err   = acc_icb_rsp_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked   <= 1'b0;
            gnt_wr   <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            if (!locked && acc_icb_cmd_valid) begin
                locked <= 1'b1;
                gnt_wr <= cur_wr;
            end
            if (acc_icb_cmd_valid && acc_icb_cmd_ready) begin
                cmd_done <= 1'b1;
            end
            if (acc_icb_rsp_valid && acc_icb_rsp_ready) begin
                locked   <= 1'b0;          // release after the response
                cmd_done <= 1'b0;
            end
        end
    end

endmodule

//--- src/map_stream.sv
/*
 * Map streaming engine
 *   - FSM reading each input word and writing the output word
 *   - per-lane multiply by weight, shift, saturate and ReLU
 *   - done pulse after the last write response
 */
`timescale 1ns/1ps

module map_stream #(
    parameter int CNT_W = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   start,
    input  acc_bus_pkg::bus_addr_t in_addr,
    input  acc_bus_pkg::bus_addr_t out_addr,
    input  logic [CNT_W-1:0]       words,
    input  acc_cfg_pkg::weight_t   weight,
    output logic                   done,

    mem_req_if.client              rd_ch,
    mem_req_if.client              wr_ch
);
    import acc_bus_pkg::*;
    import acc_cfg_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_CMD,
        S_RD_RSP,
        S_WR_CMD,
        S_WR_RSP
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] remain;              // words still to write
    bus_addr_t        rd_addr;
    bus_addr_t        wr_addr;
    weight_t          weight_q;
    bus_data_t        wdata_q;

    // ------------------------------------------------------------------
    // lane arithmetic
    // ------------------------------------------------------------------
    function automatic act_t lane_op(act_t a, weight_t w);
        logic signed [2*ACT_W-1:0] prod;
        logic signed [2*ACT_W-1:0] sat;
        prod = a * w;
        prod = prod >>> PROD_SHIFT;
        if (prod > 127) begin
            sat = 127;
        end else if (prod < -128) begin
            sat = -128;
        end else begin
            sat = prod;
        end
        if (sat < 0) begin
            sat = 0;                       // relu
        end
        return act_t'(sat);
    endfunction

    function automatic bus_data_t word_op(bus_data_t din, weight_t w);
        bus_data_t dout;
        dout = '0;
        for (int i = 0; i < LANES; i++) begin
            dout[ACT_W*i +: ACT_W] = lane_op(act_t'(din[ACT_W*i +: ACT_W]), w);
        end
        return dout;
    endfunction

    assign rd_ch.cmd_valid = (state == S_RD_CMD);
    assign rd_ch.cmd_read  = 1'b1;
    assign rd_ch.cmd_addr  = rd_addr;
    assign rd_ch.cmd_wdata = '0;
    assign rd_ch.rsp_ready = (state == S_RD_RSP);

    assign wr_ch.cmd_valid = (state == S_WR_CMD);
    assign wr_ch.cmd_read  = 1'b0;
    assign wr_ch.cmd_addr  = wr_addr;
    assign wr_ch.cmd_wdata = wdata_q;
    assign wr_ch.rsp_ready = (state == S_WR_RSP);

    // ------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            remain   <= '0;
            rd_addr  <= '0;
            wr_addr  <= '0;
            weight_q <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        remain   <= words;
                        rd_addr  <= in_addr;
                        wr_addr  <= out_addr;
                        weight_q <= weight;
                        if (words == '0) begin
                            done <= 1'b1;  // empty map
                        end else begin
                            state <= S_RD_CMD;
                        end
                    end
                end
                S_RD_CMD: if (rd_ch.cmd_ready) state <= S_RD_RSP;
                S_RD_RSP: if (rd_ch.rsp_valid) state <= S_WR_CMD;
                S_WR_CMD: if (wr_ch.cmd_ready) state <= S_WR_RSP;
                S_WR_RSP: begin
                    if (wr_ch.rsp_valid) begin
                        remain  <= remain - 1'b1;
                        rd_addr <= rd_addr + 32'd4;
                        wr_addr <= wr_addr + 32'd4;
                        if (remain == CNT_W'(1)) begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end else begin
                            state <= S_RD_CMD;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // output word, captured on the read response
    always_ff @(posedge clk) begin
        if (state == S_RD_RSP && rd_ch.rsp_valid) begin
            wdata_q <= word_op(rd_ch.rsp_rdata, weight_q);
        end
    end

endmodule

//--- src/mem_req_if.sv
/*
 * Command/response channel between a streaming client and the
 * ICB arbiter, with client and arbiter modports
 */
`timescale 1ns/1ps

interface mem_req_if;
    import acc_bus_pkg::*;

    logic      cmd_valid;
    logic      cmd_ready;
    logic      cmd_read;                   // 1 read, 0 write
    bus_addr_t cmd_addr;
    bus_data_t cmd_wdata;
    logic      rsp_valid;
    logic      rsp_ready;
    bus_data_t rsp_rdata;
    logic      rsp_err;

    modport client (
        output cmd_valid, cmd_read, cmd_addr, cmd_wdata, rsp_ready,
        input  cmd_ready, rsp_valid, rsp_rdata, rsp_err
    );

    modport arbiter (
        input  cmd_valid, cmd_read, cmd_addr, cmd_wdata, rsp_ready,
        output cmd_ready, rsp_valid, rsp_rdata, rsp_err
    );

endinterface

//--- src/repvgg_acc_top.sv
/*
 * RepVGG accelerator top level
 *   - slave register block, map streaming engine, ICB master arbiter
 */
`timescale 1ns/1ps

module repvgg_acc_top #(
    parameter int CNT_W = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // icb slave
    input  logic                   icb_cmd_valid,
    output logic                   icb_cmd_ready,
    input  logic                   icb_cmd_read,
    input  acc_bus_pkg::bus_addr_t icb_cmd_addr,
    input  acc_bus_pkg::bus_data_t icb_cmd_wdata,
    input  acc_bus_pkg::bus_mask_t icb_cmd_wmask,
    output logic                   icb_rsp_valid,
    input  logic                   icb_rsp_ready,
    output acc_bus_pkg::bus_data_t icb_rsp_rdata,
    output logic                   icb_rsp_err,

    // icb master
    output logic                   acc_icb_cmd_valid,
    input  logic                   acc_icb_cmd_ready,
    output acc_bus_pkg::bus_addr_t acc_icb_cmd_addr,
    output logic                   acc_icb_cmd_read,
    output acc_bus_pkg::bus_data_t acc_icb_cmd_wdata,
    output acc_bus_pkg::bus_mask_t acc_icb_cmd_wmask,
    input  logic                   acc_icb_rsp_valid,
    output logic                   acc_icb_rsp_ready,
    input  logic                   acc_icb_rsp_err,
    input  acc_bus_pkg::bus_data_t acc_icb_rsp_rdata
);
    import acc_bus_pkg::*;
    import acc_cfg_pkg::*;

    logic             start;
    logic             done;
    bus_addr_t        in_addr;
    bus_addr_t        out_addr;
    logic [CNT_W-1:0] words;
    weight_t          weight;

    mem_req_if rd_ch ();
    mem_req_if wr_ch ();

    acc_regs #(.CNT_W(CNT_W)) acc_regs_u (.*);

    map_stream #(.CNT_W(CNT_W)) map_stream_u (.*);

    icb_arbiter icb_arbiter_u (.*);

endmodule

//--- tb/repvgg_acc_props.sv
/*
 * Concurrent checks on the slave and master ICB ports
 *   - master command stable while stalled, writes use a full mask
 *   - slave response stable until accepted
 */
`timescale 1ns/1ps

module repvgg_acc_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   icb_rsp_valid,
    input logic                   icb_rsp_ready,
    input acc_bus_pkg::bus_data_t icb_rsp_rdata,
    input logic                   icb_rsp_err,
    input logic                   acc_icb_cmd_valid,
    input logic                   acc_icb_cmd_ready,
    input logic                   acc_icb_cmd_read,
    input acc_bus_pkg::bus_addr_t acc_icb_cmd_addr,
    input acc_bus_pkg::bus_data_t acc_icb_cmd_wdata,
    input acc_bus_pkg::bus_mask_t acc_icb_cmd_wmask
);

    int unsigned fail_count = 0;           // failed assertions so far

    cmd_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        acc_icb_cmd_valid && !acc_icb_cmd_ready |=> acc_icb_cmd_valid
            && $stable(acc_icb_cmd_addr) && $stable(acc_icb_cmd_read)
            && $stable(acc_icb_cmd_wdata))
    else begin
        $error("master command changed while stalled");
        fail_count++;
    end

    wmask_full_a: assert property (@(posedge clk) disable iff (!rst_n)
        acc_icb_cmd_valid && !acc_icb_cmd_read |-> acc_icb_cmd_wmask == '1)
    else begin
        $error("master write without a full byte mask");
        fail_count++;
    end

    rsp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        icb_rsp_valid && !icb_rsp_ready |=> icb_rsp_valid
            && $stable(icb_rsp_rdata) && $stable(icb_rsp_err))
    else begin
        $error("slave response changed before it was accepted");
        fail_count++;
    end

endmodule

bind repvgg_acc_top repvgg_acc_props repvgg_acc_props_inst (.*);

//--- tb/repvgg_acc_tb.sv
/*
 * Testbench for the accelerator top level
 *   - ICB memory model with random stalls and response delays
 *   - register readback, unmapped offset, zero length, transform,
 *     done clearing and slave back-pressure scenarios
 *   - Galois LFSR, error counts and closing report
 */
`timescale 1ns/1ps

module repvgg_acc_tb;
    import acc_bus_pkg::*;
    import acc_cfg_pkg::*;

    localparam int          MEM_WORDS  = 256;
    localparam int          TIMEOUT    = 100;      // cycles per handshake wait
    localparam int          POLL_LIMIT = 200;      // done register reads
    localparam logic [31:0] SEED       = 32'd90092;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam int          IN_IDX     = 'h40;     // word index of the input map
    localparam int          OUT_IDX    = 'h80;
    localparam int          RUN_WORDS  = 16;

    logic        clk;
    logic        rst_n;
    logic        icb_cmd_valid;
    logic        icb_cmd_ready;
    logic        icb_cmd_read;
    bus_addr_t   icb_cmd_addr;
    bus_data_t   icb_cmd_wdata;
    bus_mask_t   icb_cmd_wmask;
    logic        icb_rsp_valid;
    logic        icb_rsp_ready;
    bus_data_t   icb_rsp_rdata;
    logic        icb_rsp_err;
    logic        acc_icb_cmd_valid;
    logic        acc_icb_cmd_ready;
    bus_addr_t   acc_icb_cmd_addr;
    logic        acc_icb_cmd_read;
    bus_data_t   acc_icb_cmd_wdata;
    bus_mask_t   acc_icb_cmd_wmask;
    logic        acc_icb_rsp_valid;
    logic        acc_icb_rsp_ready;
    logic        acc_icb_rsp_err;
    bus_data_t   acc_icb_rsp_rdata;

    bus_data_t   mem [MEM_WORDS];
    int          rd_count [MEM_WORDS];
    bus_data_t   in_words [RUN_WORDS];
    int          cmd_count;
    int          errors;
    int          timeouts;
    logic [31:0] lfsr_state;
    weight_t     run_weight;

    tb_clk_gen clk_gen_u (.clk(clk), .rst_n(rst_n));

    repvgg_acc_top repvgg_acc_top_inst (.*);

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic bus_data_t fill_word(int idx);
        return 32'hC0DE_0000 ^ bus_data_t'(idx * 4);  // byte address folded in
    endfunction

    function automatic logic [7:0] expect_lane(logic [7:0] a, logic [7:0] w);
        int p;
        p = int'($signed(a)) * int'($signed(w));
        p = p >>> PROD_SHIFT;
        if (p > 127) p = 127;
        if (p < 0) p = 0;                  // relu also covers the low clamp
        return p[7:0];
    endfunction

    function automatic bus_data_t expect_word(bus_data_t din, logic [7:0] w);
        bus_data_t r;
        for (int l = 0; l < LANES; l++) begin
            r[8*l +: 8] = expect_lane(din[8*l +: 8], w);
        end
        return r;
    endfunction

    function automatic bus_addr_t reg_addr(reg_off_t off);
        return {24'h0, off};
    endfunction

    function automatic void check_equal(string name, logic [31:0] exp, logic [31:0] got);
        assert (got === exp) else begin
            $display("mismatch %s: expected %h, actual %h", name, exp, got);
            errors++;
        end
    endfunction

    // ------------------------------------------------------------------
    // slave port transactions
    // ------------------------------------------------------------------
    task automatic send_cmd(input logic rd, input bus_addr_t addr, input bus_data_t data,
                            input bus_mask_t mask);
        int t;
        @(negedge clk);
        icb_cmd_valid = 1'b1;
        icb_cmd_read  = rd;
        icb_cmd_addr  = addr;
        icb_cmd_wdata = data;
        icb_cmd_wmask = mask;
        t = 0;
        while (!icb_cmd_ready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        assert (icb_cmd_ready) else begin
            $display("timeout: slave port never accepted the command to %h", addr);
            timeouts++;
        end
        @(negedge clk);                    // taken at the edge just passed
        icb_cmd_valid = 1'b0;
    endtask

    task automatic take_rsp(input int hold, output bus_data_t rdata, output logic err);
        int t;
        t = 0;
        while (!icb_rsp_valid && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        assert (icb_rsp_valid) else begin
            $display("timeout: slave port gave no response");
            timeouts++;
        end
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_equal("held_rsp_cmd_ready", 0, icb_cmd_ready);
            check_equal("held_rsp_valid", 1, icb_rsp_valid);
        end
        icb_rsp_ready = 1'b1;
        rdata = icb_rsp_rdata;
        err   = icb_rsp_err;
        @(negedge clk);
        icb_rsp_ready = 1'b0;
    endtask

    task automatic reg_write(input bus_addr_t addr, input bus_data_t data, input bus_mask_t mask);
        bus_data_t d;
        logic      e;
        send_cmd(1'b0, addr, data, mask);
        take_rsp(0, d, e);
    endtask

    task automatic reg_read(input bus_addr_t addr, input int hold, output bus_data_t d,
                            output logic e);
        send_cmd(1'b1, addr, '0, '0);
        take_rsp(hold, d, e);
    endtask

    task automatic wait_done(input string name);
        bus_data_t d;
        logic      e;
        int        n;
        d = '0;
        n = 0;
        while (!d[0] && n < POLL_LIMIT) begin
            reg_read(reg_addr(REG_DONE), 0, d, e);
            n++;
        end
        assert (d[0]) else begin
            $display("timeout: %s run never set the done flag", name);
            timeouts++;
        end
    endtask

    // ------------------------------------------------------------------
    // ICB memory model on the master port
    // ------------------------------------------------------------------
    initial begin : mem_model
        logic      pending;
        logic      rsp_fire;
        int        delay;
        int        idx;
        bus_data_t rsp_data;
        pending  = 1'b0;
        rsp_fire = 1'b0;
        delay    = 0;
        rsp_data = '0;
        forever begin
            @(negedge clk);
            if (rsp_fire) begin            // response taken at the last edge
                acc_icb_rsp_valid = 1'b0;
                rsp_fire = 1'b0;
                pending  = 1'b0;
            end
            if (pending && !acc_icb_rsp_valid) begin
                if (delay == 0) begin
                    acc_icb_rsp_valid = 1'b1;
                    acc_icb_rsp_rdata = rsp_data;
                end else begin
                    delay--;
                end
            end
            if (acc_icb_rsp_valid && acc_icb_rsp_ready) rsp_fire = 1'b1;
            acc_icb_cmd_ready = 1'b0;
            if (!pending && acc_icb_cmd_valid) begin
                acc_icb_cmd_ready = (rand_bits(2) != 0);  // stall one time in four
                if (acc_icb_cmd_ready) begin
                    assert (acc_icb_cmd_addr < bus_addr_t'(MEM_WORDS * 4)) else begin
                        $display("master access at %h is outside the memory", acc_icb_cmd_addr);
                        errors++;
                    end
                    idx = int'(acc_icb_cmd_addr[9:2]);
                    rsp_data = '0;
                    if (acc_icb_cmd_read) begin
                        rsp_data = mem[idx];
                        rd_count[idx]++;
                    end else begin
                        mem[idx] = acc_icb_cmd_wdata;
                    end
                    cmd_count++;
                    pending = 1'b1;
                    delay   = int'(rand_bits(2));
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // stimulus and checks
    // ------------------------------------------------------------------
    initial begin : stimulus
        bus_data_t d;
        logic      e;
        int        t;
        int        base_count;
        icb_cmd_valid     = 1'b0;
        icb_cmd_read      = 1'b0;
        icb_cmd_addr      = '0;
        icb_cmd_wdata     = '0;
        icb_cmd_wmask     = '0;
        icb_rsp_ready     = 1'b0;
        acc_icb_cmd_ready = 1'b0;
        acc_icb_rsp_valid = 1'b0;
        acc_icb_rsp_err   = 1'b0;
        acc_icb_rsp_rdata = '0;
        lfsr_state = SEED;
        errors     = 0;
        timeouts   = 0;
        cmd_count  = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]      = fill_word(i);
            rd_count[i] = 0;
        end
        run_weight = weight_t'(32'h40 | rand_bits(6));  // large enough to saturate
        for (int i = 0; i < RUN_WORDS; i++) begin
            in_words[i] = rand_bits(32);
        end
        in_words[0][15:0] = 16'h807F;      // one lane saturates, one clamps to 0
        in_words[1][7:0]  = 8'h03;         // stays in range
        for (int i = 0; i < RUN_WORDS; i++) begin
            mem[IN_IDX + i] = in_words[i];
        end

        t = 0;
        while (!rst_n && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        assert (rst_n) else begin
            $display("timeout: reset was never released");
            timeouts++;
        end

        // register readback with byte masks
        reg_write(reg_addr(REG_IN_ADDR), 32'h5A5A_5A5A, 4'hF);
        reg_write(reg_addr(REG_IN_ADDR), 32'h0000_0100, 4'b1100);  // upper bytes only
        reg_write(reg_addr(REG_OUT_ADDR), 32'h0000_0200, 4'hF);
        reg_write(reg_addr(REG_WORDS), 32'hABCD_0010, 4'hF);
        reg_write(reg_addr(REG_WEIGHT), 32'h1234_56F3, 4'hF);
        reg_write(reg_addr(REG_WEIGHT), 32'h0000_0077, 4'h0);      // empty mask
        reg_read(reg_addr(REG_IN_ADDR), 0, d, e);
        check_equal("readback_in_addr", 32'h0000_5A5A, d);
        check_equal("readback_err", 0, e);
        reg_read(reg_addr(REG_OUT_ADDR), 0, d, e);
        check_equal("readback_out_addr", 32'h0000_0200, d);
        reg_read(reg_addr(REG_WORDS), 0, d, e);
        check_equal("readback_words", 32'h0000_0010, d);
        reg_read(reg_addr(REG_WEIGHT), 0, d, e);
        check_equal("readback_weight", 32'h0000_00F3, d);
        reg_read(reg_addr(REG_START), 0, d, e);
        check_equal("readback_start", 32'h0, d);

        // unmapped offset
        reg_read(32'h0000_0040, 0, d, e);
        check_equal("unmapped_err", 1, e);
        check_equal("unmapped_rdata", 32'h0, d);

        // zero-length run, no master traffic
        base_count = cmd_count;
        reg_write(reg_addr(REG_WORDS), 32'h0, 4'hF);
        reg_write(reg_addr(REG_START), 32'h1, 4'hF);
        wait_done("zero length");
        check_equal("zero_length_cmds", base_count, cmd_count);

        // transform run under master stalls and delays
        base_count = cmd_count;
        reg_write(reg_addr(REG_IN_ADDR), bus_data_t'(IN_IDX * 4), 4'hF);
        reg_write(reg_addr(REG_OUT_ADDR), bus_data_t'(OUT_IDX * 4), 4'hF);
        reg_write(reg_addr(REG_WORDS), bus_data_t'(RUN_WORDS), 4'hF);
        reg_write(reg_addr(REG_WEIGHT), {24'h0, run_weight}, 4'hF);
        reg_write(reg_addr(REG_START), 32'h1, 4'hF);
        reg_read(reg_addr(REG_DONE), 0, d, e);
        check_equal("done_cleared_by_start", 32'h0, d);
        wait_done("transform");
        for (int i = 0; i < RUN_WORDS; i++) begin
            check_equal($sformatf("transform_word_%0d", i),
                        expect_word(in_words[i], run_weight), mem[OUT_IDX + i]);
            check_equal($sformatf("input_reads_%0d", i), 1, rd_count[IN_IDX + i]);
        end
        check_equal("past_map_end", fill_word(OUT_IDX + RUN_WORDS), mem[OUT_IDX + RUN_WORDS]);
        check_equal("master_cmd_count", base_count + 2 * RUN_WORDS, cmd_count);

        // slave back-pressure on a read response
        reg_read(reg_addr(REG_WEIGHT), 6, d, e);
        check_equal("held_rsp_rdata", {24'h0, run_weight}, d);

        $display("%0d check errors, %0d timeouts, %0d property failures", errors, timeouts,
                 repvgg_acc_top_inst.repvgg_acc_props_inst.fail_count);
        if (errors == 0 && timeouts == 0
                && repvgg_acc_top_inst.repvgg_acc_props_inst.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb/tb_clk_gen.sv
/*
 * Testbench clock and reset
 *   - 4 ns clock, reset held low for 8 cycles
 */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;             // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                    // release away from the active edge
        rst_n = 1'b1;
    end

endmodule
